// ==== compile.f ====
hw/nrf_pkg.sv
hw/nrf_fifo.sv
hw/nrf_sequencer.sv
hw/nrf_txn_engine.sv
hw/nrf_top.sv
dv/nrf_radio_model.sv
dv/nrf_tb.sv

// ==== dv/nrf_radio_model.sv ====
// behavioural nrf24l01 radio with spi byte replies, transaction log, rx payload queue and irq
`timescale 1ns/1ns

module nrf_radio_model import nrf_pkg::*; #(
	parameter int SEED    = 1,
	parameter int LOG_MAX = 64
) (
	input  logic       CLK,
	input  logic       RSTn,
	input  logic       CSN,
	input  logic       spi_valid,
	output logic       spi_ready,
	input  logic [7:0] spi_data,
	output logic       spi_rx_valid,
	output logic [7:0] spi_rx_data,
	output logic       IRQ,
	input  logic       irq_req,                // raise irq with irq_status
	input  logic [7:0] irq_status,
	input  logic       pld_valid,              // queue one rx payload byte
	input  logic [7:0] pld_data
);

	typedef enum logic [1:0] {M_IDLE, M_READY, M_REPLY} model_state_e;

	model_state_e st;
	integer       seed;
	int           wait_cnt;
	int           idx;                         // byte position in the csn frame
	logic [7:0]   cur_op;
	logic [7:0]   stat;                        // status register
	logic [7:0]   reply;
	logic [7:0]   reply_q;
	logic [7:0]   pld_q [$];
	int           log_count;
	logic [7:0]   log_op   [LOG_MAX];
	int           log_len  [LOG_MAX];
	logic [7:0]   log_data [LOG_MAX][32];

	initial seed = SEED;

	function automatic int pick_delay();
		return $unsigned($random(seed)) % 4;   // 0 to 3 cycles
	endfunction

	always @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			st           <= M_IDLE;
			spi_ready    <= 1'b0;
			spi_rx_valid <= 1'b0;
			spi_rx_data  <= 8'h00;
			IRQ          <= 1'b1;
			stat         <= 8'h0E;             // rx fifo empty
			idx          <= 0;
			cur_op       <= 8'h00;
			reply_q      <= 8'h00;
			wait_cnt     <= 0;
			log_count    <= 0;
		end else begin
			spi_rx_valid <= 1'b0;
			if (pld_valid) begin
				pld_q.push_back(pld_data);
			end
			if (irq_req) begin
				stat <= stat | irq_status;
				IRQ  <= 1'b0;
			end
			if (CSN) begin
				idx <= 0;                      // new frame starts at the opcode
			end
			case (st)
				M_IDLE: begin
					if (wait_cnt == 0) begin
						spi_ready <= 1'b1;
						st        <= M_READY;
					end else begin
						wait_cnt <= wait_cnt - 1;
					end
				end
				M_READY: begin
					if (spi_valid) begin
						if (idx == 0 || cur_op != CMD_RD_RX_PLOAD) begin
							reply = stat;
						end else if (pld_q.size() > 0) begin
							reply = pld_q.pop_front();
						end else begin
							reply = 8'h00;
						end
						if (idx == 0) begin
							cur_op <= spi_data;
							if (log_count < LOG_MAX) begin
								log_op[log_count]  <= spi_data;
								log_len[log_count] <= 0;
							end
							log_count <= log_count + 1;
						end else if (log_count <= LOG_MAX && idx <= 32) begin
							log_data[log_count-1][idx-1] <= spi_data;
							log_len[log_count-1]         <= idx;
						end
						if (idx == 1 && cur_op == (CMD_W_REGISTER | REG_STATUS)) begin
							stat <= stat & ~spi_data;  // write one to clear
							if ((spi_data & STATUS_CLEAR) == STATUS_CLEAR) begin
								IRQ <= 1'b1;
							end
						end
						idx       <= idx + 1;
						spi_ready <= 1'b0;
						reply_q   <= reply;
						wait_cnt  <= pick_delay();
						st        <= M_REPLY;
					end
				end
				default: begin
					if (wait_cnt == 0) begin
						spi_rx_valid <= 1'b1;
						spi_rx_data  <= reply_q;
						wait_cnt     <= pick_delay();
						st           <= M_IDLE;
					end else begin
						wait_cnt <= wait_cnt - 1;
					end
				end
			endcase
		end
	end

endmodule

// ==== dv/nrf_tb.sv ====
// nrf24l01 controller testbench with clock, reset, timeout, directed tests and summary line
`timescale 1ns/1ns

module nrf_tb import nrf_pkg::*; ();

	localparam int PLD        = 32;
	localparam int CE_HOLD    = 50;
	localparam int RXQ_D      = 16;
	localparam int MAX_CYCLES = 20000;     // six tests of up to ~3000 cycles
	localparam int SEED       = 32'hdebcd0f9;

	logic       CLK;
	logic       RSTn;
	logic       IRQ;
	logic       CE;
	logic       CSN;
	logic       tx_valid;
	logic       tx_ready;
	logic [7:0] tx_data;
	logic       rx_valid;
	logic       rx_ready;
	nrf_rx_t    rx_data;
	logic       spi_valid;
	logic       spi_ready;
	logic [7:0] spi_data;
	logic       spi_rx_valid;
	logic [7:0] spi_rx_data;
	logic       irq_req;
	logic [7:0] irq_status;
	logic       pld_valid;
	logic [7:0] pld_data;

	integer     seed;
	int         errors;
	int         checks;
	int         cycles;
	logic [7:0] exp_bytes [32];            // expected data bytes of one transaction
	int         exp_len;
	logic [7:0] tx_bytes [32];
	logic [7:0] rx_bytes [32];

	nrf_top #(
		.PAYLOAD_BYTES(PLD),
		.CE_HOLD_CYCLES(CE_HOLD),
		.RXQ_DEPTH(RXQ_D)
	) uut (
		.CLK(CLK), .RSTn(RSTn), .IRQ(IRQ), .CE(CE), .CSN(CSN),
		.tx_valid(tx_valid), .tx_ready(tx_ready), .tx_data(tx_data),
		.rx_valid(rx_valid), .rx_ready(rx_ready), .rx_data(rx_data),
		.spi_valid(spi_valid), .spi_ready(spi_ready), .spi_data(spi_data),
		.spi_rx_valid(spi_rx_valid), .spi_rx_data(spi_rx_data)
	);

	nrf_radio_model #(.SEED(SEED)) radio (
		.CLK(CLK), .RSTn(RSTn), .CSN(CSN),
		.spi_valid(spi_valid), .spi_ready(spi_ready), .spi_data(spi_data),
		.spi_rx_valid(spi_rx_valid), .spi_rx_data(spi_rx_data), .IRQ(IRQ),
		.irq_req(irq_req), .irq_status(irq_status),
		.pld_valid(pld_valid), .pld_data(pld_data)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge CLK);
			cycles++;
		end
		errors++;
		$display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
		$display("checks %0d, errors %0d", checks, errors);
		$display("Testbench failed");
		$finish;
	end

	task automatic check_value(input string test, input string what,
			input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (exp === act) else begin
			errors++;
			$display("FAIL %s %s: expected 0x%0h, actual 0x%0h", test, what, exp, act);
		end
	endtask

	// waits until transaction n-1 has been logged and its frame has ended
	task automatic wait_txns(input int n);
		@(negedge CLK);
		while (radio.log_count < n || CSN !== 1'b1) begin
			@(negedge CLK);
		end
	endtask

	task automatic check_txn(input string test, input int n, input logic [7:0] op);
		int i;
		checks++;
		assert (n < radio.log_count) else begin
			errors++;
			$display("%s: transaction %0d never appeared on the SPI bus", test, n);
		end
		if (n < radio.log_count) begin
			check_value(test, $sformatf("txn %0d opcode", n), op, radio.log_op[n]);
			check_value(test, $sformatf("txn %0d length", n), exp_len, radio.log_len[n]);
			for (i = 0; i < exp_len && i < radio.log_len[n]; i++) begin
				check_value(test, $sformatf("txn %0d byte %0d", n, i), exp_bytes[i],
						radio.log_data[n][i]);
			end
		end
	endtask

	task automatic expect_write(input string test, input int n, input logic [7:0] addr,
			input logic [7:0] val);
		exp_bytes[0] = val;
		exp_len      = 1;
		check_txn(test, n, CMD_W_REGISTER | addr);
	endtask

	task automatic expect_cmd(input string test, input int n, input logic [7:0] op);
		exp_len = 0;
		check_txn(test, n, op);
	endtask

	task automatic raise_irq(input logic [7:0] flags);
		@(posedge CLK);
		irq_req    <= 1'b1;
		irq_status <= flags;
		@(posedge CLK);
		irq_req <= 1'b0;
	endtask

	task automatic check_idle_outputs(input string test);
		check_value(test, "CSN", 1, CSN);
		check_value(test, "CE", 0, CE);
		check_value(test, "spi_valid", 0, spi_valid);
		check_value(test, "rx_valid", 0, rx_valid);
		check_value(test, "tx_ready", 1, tx_ready);
	endtask

	task automatic reset_test();
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		check_idle_outputs("reset");
		@(posedge CLK);
		RSTn <= 1'b1;                      // fourth edge ends reset
		@(negedge CLK);
		check_idle_outputs("reset");
		@(negedge CLK);
		check_idle_outputs("after reset");
	endtask

	task automatic setup_test();
		int i;
		wait_txns(12);
		for (i = 0; i < ADDR_BYTES; i++) begin
			exp_bytes[i] = NODE_ADDR[i];
		end
		exp_len = ADDR_BYTES;
		check_txn("setup", 0, CMD_W_REGISTER | REG_RX_ADDR_P0);
		check_txn("setup", 1, CMD_W_REGISTER | REG_TX_ADDR);
		expect_write("setup", 2, REG_EN_AA, 8'h00);
		expect_write("setup", 3, REG_EN_RXADDR, 8'h01);
		expect_write("setup", 4, REG_SETUP_RETR, 8'h00);
		expect_write("setup", 5, REG_RF_CH, RF_CHANNEL);
		expect_write("setup", 6, REG_RF_SETUP, RF_SETUP_VAL);
		expect_write("setup", 7, REG_STATUS, STATUS_CLEAR);
		expect_cmd("setup", 8, CMD_FLUSH_RX);
		expect_cmd("setup", 9, CMD_FLUSH_TX);
		expect_write("setup", 10, REG_RX_PW_P0, PLD);
		expect_write("setup", 11, REG_CONFIG, CONFIG_RX);
		repeat (2) @(negedge CLK);
		check_value("setup", "CE", 1, CE);
		check_value("setup", "transaction count", 12, radio.log_count);
	endtask

	task automatic tx_test();
		int i;
		int r;
		int base;
		int hold;
		base = radio.log_count;
		for (i = 0; i < PLD; i++) begin
			r           = $random(seed);
			tx_bytes[i] = r[7:0];
			@(posedge CLK);
			tx_valid <= 1'b1;
			tx_data  <= r[7:0];
			@(negedge CLK);
			while (tx_ready !== 1'b1) begin
				@(negedge CLK);
			end
		end
		@(posedge CLK);
		tx_valid <= 1'b0;
		wait_txns(base + 2);
		check_value("transmit", "CE before pulse", 0, CE);
		expect_write("transmit", base, REG_CONFIG, CONFIG_TX);
		for (i = 0; i < PLD; i++) begin
			exp_bytes[i] = tx_bytes[i];
		end
		exp_len = PLD;
		check_txn("transmit", base + 1, CMD_WR_TX_PLOAD);
		while (CE !== 1'b1) begin
			@(negedge CLK);
		end
		hold = 0;
		while (CE === 1'b1) begin          // one negedge per high cycle
			hold++;
			@(negedge CLK);
		end
		check_value("transmit", "CE high cycles", CE_HOLD, hold);
	endtask

	task automatic tx_irq_test();
		int base;
		base = radio.log_count;
		raise_irq(STATUS_TX_DS);
		wait_txns(base + 3);
		expect_write("tx interrupt", base, REG_STATUS, STATUS_CLEAR);
		expect_cmd("tx interrupt", base + 1, CMD_FLUSH_TX);
		expect_write("tx interrupt", base + 2, REG_CONFIG, CONFIG_RX);
		repeat (2) @(negedge CLK);
		check_value("tx interrupt", "CE", 1, CE);
		check_value("tx interrupt", "IRQ", 1, IRQ);
	endtask

	task automatic rx_test();
		int i;
		int r;
		int base;
		int got;
		base = radio.log_count;
		@(posedge CLK);
		rx_ready <= 1'b0;
		for (i = 0; i < PLD; i++) begin
			r           = $random(seed);
			rx_bytes[i] = r[7:0];
			@(posedge CLK);
			pld_valid <= 1'b1;
			pld_data  <= r[7:0];
		end
		@(posedge CLK);
		pld_valid <= 1'b0;
		raise_irq(STATUS_RX_DR);
		repeat (497) @(posedge CLK);       // host stalls the rx stream
		@(negedge CLK);
		check_value("receive", "CSN while stalled", 0, CSN);
		check_value("receive", "rx_valid while stalled", 1, rx_valid);
		check_value("receive", "bytes read before stall", RXQ_D, radio.log_len[base + 1]);
		@(posedge CLK);
		rx_ready <= 1'b1;
		got = 0;
		while (got < PLD) begin
			@(negedge CLK);
			if (rx_valid === 1'b1) begin
				check_value("receive", $sformatf("byte %0d", got), rx_bytes[got],
						rx_data.data);
				check_value("receive", $sformatf("last flag %0d", got), got == PLD - 1,
						rx_data.last);
				got++;
			end
		end
		wait_txns(base + 3);
		expect_write("receive", base, REG_STATUS, STATUS_CLEAR);
		for (i = 0; i < PLD; i++) begin
			exp_bytes[i] = CMD_NOP;
		end
		exp_len = PLD;
		check_txn("receive", base + 1, CMD_RD_RX_PLOAD);
		expect_cmd("receive", base + 2, CMD_FLUSH_RX);
		check_value("receive", "rx_valid after payload", 0, rx_valid);
	endtask

	task automatic spurious_test();
		int base;
		base = radio.log_count;
		raise_irq(8'h00);
		wait_txns(base + 1);
		expect_write("spurious", base, REG_STATUS, STATUS_CLEAR);
		repeat (200) @(negedge CLK);
		check_value("spurious", "transaction count", base + 1, radio.log_count);
		check_value("spurious", "IRQ", 1, IRQ);
	endtask

	initial begin
		seed       = SEED;
		errors     = 0;
		checks     = 0;
		RSTn       = 1'b0;
		tx_valid   = 1'b0;
		tx_data    = 8'h00;
		rx_ready   = 1'b1;
		irq_req    = 1'b0;
		irq_status = 8'h00;
		pld_valid  = 1'b0;
		pld_data   = 8'h00;
		reset_test();
		setup_test();
		tx_test();
		tx_irq_test();
		rx_test();
		spurious_test();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== hw/nrf_fifo.sv ====
// first-word-fall-through fifo with a typed entry and fill level
`timescale 1ns/1ns

module nrf_fifo import nrf_pkg::*; #(
	parameter type entry_t = logic [7:0],
	parameter int  DEPTH   = 16
) (
	input  logic               CLK,
	input  logic               RSTn,
	input  logic               in_valid,
	output logic               in_ready,
	input  entry_t             in_data,
	output logic               out_valid,
	input  logic               out_ready,
	output entry_t             out_data,
	output logic [LEVEL_W-1:0] level
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	entry_t             mem [DEPTH];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [LEVEL_W-1:0] count;
	logic               push;
	logic               pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;    // wrap for any depth
	endfunction

	assign in_ready  = (count != LEVEL_W'(DEPTH));
	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];                        // head is always visible
	assign push      = in_valid & in_ready;
	assign pop       = out_valid & out_ready;
	assign level     = count;

	always_ff @(posedge CLK) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;                   // both or neither
			endcase
		end
	end

endmodule

// ==== hw/nrf_pkg.sv ====
// nrf24l01 command codes, register map, setup values, status flags and transaction types
package nrf_pkg;

	localparam int LEVEL_W = 8;                       // fifo fill level width

	localparam logic [7:0] CMD_W_REGISTER  = 8'h20;   // or'd with register address
	localparam logic [7:0] CMD_RD_RX_PLOAD = 8'h61;
	localparam logic [7:0] CMD_WR_TX_PLOAD = 8'hA0;
	localparam logic [7:0] CMD_FLUSH_TX    = 8'hE1;
	localparam logic [7:0] CMD_FLUSH_RX    = 8'hE2;
	localparam logic [7:0] CMD_NOP         = 8'hFF;   // clocked out while reading

	localparam logic [7:0] REG_CONFIG     = 8'h00;
	localparam logic [7:0] REG_EN_AA      = 8'h01;
	localparam logic [7:0] REG_EN_RXADDR  = 8'h02;
	localparam logic [7:0] REG_SETUP_RETR = 8'h04;
	localparam logic [7:0] REG_RF_CH      = 8'h05;
	localparam logic [7:0] REG_RF_SETUP   = 8'h06;
	localparam logic [7:0] REG_STATUS     = 8'h07;
	localparam logic [7:0] REG_RX_ADDR_P0 = 8'h0A;
	localparam logic [7:0] REG_TX_ADDR    = 8'h10;
	localparam logic [7:0] REG_RX_PW_P0   = 8'h11;

	localparam int ADDR_BYTES = 5;
	localparam logic [0:ADDR_BYTES-1][7:0] NODE_ADDR = {8'h34, 8'h43, 8'h10, 8'h10, 8'h01};

	localparam logic [7:0] RF_CHANNEL   = 8'd40;
	localparam logic [7:0] CONFIG_RX    = 8'h1F;      // pwr up, crc16, prim_rx
	localparam logic [7:0] CONFIG_TX    = 8'h1E;
	localparam logic [7:0] RF_SETUP_VAL = 8'h0F;      // 2 mbps, 0 dbm, lna on

	localparam logic [7:0] STATUS_TX_DS  = 8'h20;
	localparam logic [7:0] STATUS_RX_DR  = 8'h40;
	localparam logic [7:0] STATUS_MAX_RT = 8'h10;
	localparam logic [7:0] STATUS_CLEAR  = STATUS_TX_DS | STATUS_RX_DR | STATUS_MAX_RT;

	// where the data bytes of a transaction come from
	typedef enum logic [1:0] {
		SRC_FIXED,                                    // repeat data field
		SRC_ADDR,                                     // node address bytes
		SRC_TXQ,                                      // tx payload fifo
		SRC_READ                                      // send nop, keep replies
	} nrf_src_e;

	typedef struct packed {
		logic [7:0] opcode;
		logic [5:0] len;                              // data bytes after opcode
		nrf_src_e   src;
		logic [7:0] data;
	} nrf_txn_t;

	typedef struct packed {
		logic [7:0] data;
		logic       last;                             // final byte of a payload
	} nrf_rx_t;

endpackage

// ==== hw/nrf_sequencer.sv ====
// radio control fsm with setup, transmit, interrupt and receive phases, irq edge and ce timing
`timescale 1ns/1ns

module nrf_sequencer import nrf_pkg::*; #(
	parameter int PAYLOAD_BYTES  = 32,
	parameter int CE_HOLD_CYCLES = 50
) (
	input  logic               CLK,
	input  logic               RSTn,
	input  logic               IRQ,
	output logic               CE,
	output logic               cmd_valid,
	input  logic               cmd_ready,
	output nrf_txn_t           cmd_data,
	input  logic               txn_done,
	input  logic [7:0]         status,
	input  logic [LEVEL_W-1:0] tx_level
);

	localparam int         HOLD_W    = $clog2(CE_HOLD_CYCLES + 1);
	localparam logic [5:0] PLD_LEN   = 6'(PAYLOAD_BYTES);
	localparam logic [7:0] PLD_BYTE  = 8'(PAYLOAD_BYTES);
	localparam logic [LEVEL_W-1:0] PLD_LEVEL = LEVEL_W'(PAYLOAD_BYTES);

	typedef enum logic [2:0] {SETUP, LISTEN, SEND, CE_PULSE, INTR, REACT} seq_state_e;

	seq_state_e        st;
	logic [3:0]        step;          // commands pushed in this phase
	logic [3:0]        n_cmds;        // commands the phase has
	logic [5:0]        pend;          // pushed but not yet done
	logic [HOLD_W-1:0] hold_cnt;
	logic              irq_q;
	logic              irq_fall;
	logic [7:0]        irq_status;
	logic              push;
	logic              drained;
	logic              phase_end;

	function automatic nrf_txn_t mk_txn(input logic [7:0] opcode, input logic [5:0] len,
			input nrf_src_e src, input logic [7:0] data);
		nrf_txn_t t;
		t.opcode = opcode;
		t.len    = len;
		t.src    = src;
		t.data   = data;
		return t;
	endfunction

	function automatic nrf_txn_t wr_reg(input logic [7:0] addr, input logic [7:0] val);
		return mk_txn(CMD_W_REGISTER | addr, 6'd1, SRC_FIXED, val);
	endfunction

	// command table, indexed by phase and step
	always_comb begin
		n_cmds   = 4'd0;
		cmd_data = mk_txn(CMD_NOP, 6'd0, SRC_FIXED, 8'h00);
		case (st)
			SETUP: begin
				n_cmds = 4'd12;
				case (step)
					4'd0:  cmd_data = mk_txn(CMD_W_REGISTER | REG_RX_ADDR_P0,
							6'(ADDR_BYTES), SRC_ADDR, 8'h00);
					4'd1:  cmd_data = mk_txn(CMD_W_REGISTER | REG_TX_ADDR,
							6'(ADDR_BYTES), SRC_ADDR, 8'h00);
					4'd2:  cmd_data = wr_reg(REG_EN_AA, 8'h00);          // no auto ack
					4'd3:  cmd_data = wr_reg(REG_EN_RXADDR, 8'h01);      // pipe 0 only
					4'd4:  cmd_data = wr_reg(REG_SETUP_RETR, 8'h00);     // no retransmit
					4'd5:  cmd_data = wr_reg(REG_RF_CH, RF_CHANNEL);
					4'd6:  cmd_data = wr_reg(REG_RF_SETUP, RF_SETUP_VAL);
					4'd7:  cmd_data = wr_reg(REG_STATUS, STATUS_CLEAR);
					4'd8:  cmd_data = mk_txn(CMD_FLUSH_RX, 6'd0, SRC_FIXED, 8'h00);
					4'd9:  cmd_data = mk_txn(CMD_FLUSH_TX, 6'd0, SRC_FIXED, 8'h00);
					4'd10: cmd_data = wr_reg(REG_RX_PW_P0, PLD_BYTE);
					default: cmd_data = wr_reg(REG_CONFIG, CONFIG_RX);
				endcase
			end
			SEND: begin
				n_cmds   = 4'd2;
				cmd_data = (step == 4'd0) ? wr_reg(REG_CONFIG, CONFIG_TX)
						: mk_txn(CMD_WR_TX_PLOAD, PLD_LEN, SRC_TXQ, 8'h00);
			end
			INTR: begin
				n_cmds   = 4'd1;
				cmd_data = wr_reg(REG_STATUS, STATUS_CLEAR);
			end
			REACT: begin
				if ((irq_status & STATUS_TX_DS) != 8'h00) begin     // sent, back to rx
					n_cmds   = 4'd2;
					cmd_data = (step == 4'd0) ? mk_txn(CMD_FLUSH_TX, 6'd0, SRC_FIXED, 8'h00)
							: wr_reg(REG_CONFIG, CONFIG_RX);
				end else if ((irq_status & STATUS_RX_DR) != 8'h00) begin
					n_cmds   = 4'd2;
					cmd_data = (step == 4'd0) ? mk_txn(CMD_RD_RX_PLOAD, PLD_LEN, SRC_READ, 8'h00)
							: mk_txn(CMD_FLUSH_RX, 6'd0, SRC_FIXED, 8'h00);
				end
			end
			default: n_cmds = 4'd0;
		endcase
	end

	assign cmd_valid = (step < n_cmds);
	assign push      = cmd_valid & cmd_ready;
	assign drained   = (pend == {5'd0, txn_done});   // last one finishing now
	assign phase_end = (step == n_cmds) && drained;

	always_ff @(posedge CLK) begin
		if (st == INTR && phase_end) begin
			irq_status <= status;                     // reply to the status clear
		end
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			st       <= SETUP;
			step     <= '0;
			pend     <= '0;
			CE       <= 1'b0;
			hold_cnt <= '0;
			irq_q    <= 1'b1;
			irq_fall <= 1'b0;
		end else begin
			irq_q    <= IRQ;
			irq_fall <= irq_q & ~IRQ;
			case ({push, txn_done})
				2'b10:   pend <= pend + 1'b1;
				2'b01:   pend <= pend - 1'b1;
				default: pend <= pend;
			endcase
			if (push) begin
				step <= step + 1'b1;
			end
			case (st)
				SETUP: begin
					if (phase_end) begin
						st <= LISTEN;
						CE <= 1'b1;                   // start listening
					end
				end
				LISTEN: begin
					if (irq_fall) begin
						st   <= INTR;
						step <= '0;
					end else if (tx_level >= PLD_LEVEL) begin
						st   <= SEND;
						step <= '0;
						CE   <= 1'b0;
					end
				end
				SEND: begin
					if (phase_end) begin
						st       <= CE_PULSE;
						CE       <= 1'b1;
						hold_cnt <= HOLD_W'(CE_HOLD_CYCLES - 1);
					end
				end
				CE_PULSE: begin
					if (hold_cnt == '0) begin
						st <= LISTEN;
						CE <= 1'b0;
					end else begin
						hold_cnt <= hold_cnt - 1'b1;
					end
				end
				INTR: begin
					if (phase_end) begin
						st   <= REACT;
						step <= '0;
					end
				end
				default: begin
					if (phase_end) begin
						st <= LISTEN;
						if ((irq_status & STATUS_TX_DS) != 8'h00) begin
							CE <= 1'b1;
						end
					end
				end
			endcase
		end
	end

endmodule

// ==== hw/nrf_top.sv ====
// nrf24l01 controller top with sequencer, command, tx and rx fifos and transaction engine
`timescale 1ns/1ns

module nrf_top import nrf_pkg::*; #(
	parameter int PAYLOAD_BYTES  = 32,
	parameter int CE_HOLD_CYCLES = 50,
	parameter int CMD_DEPTH      = 16,
	parameter int TXQ_DEPTH      = 64,
	parameter int RXQ_DEPTH      = 16
) (
	input  logic       CLK,
	input  logic       RSTn,
	input  logic       IRQ,
	output logic       CE,
	output logic       CSN,
	input  logic       tx_valid,
	output logic       tx_ready,
	input  logic [7:0] tx_data,
	output logic       rx_valid,
	input  logic       rx_ready,
	output nrf_rx_t    rx_data,
	output logic       spi_valid,
	input  logic       spi_ready,
	output logic [7:0] spi_data,
	input  logic       spi_rx_valid,
	input  logic [7:0] spi_rx_data
);

	nrf_txn_t           cmd_data;
	logic               cmd_valid;
	logic               cmd_ready;
	nrf_txn_t           txn_data;
	logic               txn_valid;
	logic               txn_ready;
	logic               txq_valid;
	logic               txq_ready;
	logic [7:0]         txq_data;
	logic [LEVEL_W-1:0] tx_level;
	nrf_rx_t            rxq_data;
	logic               rxq_valid;
	logic               rxq_ready;
	logic               txn_done;
	logic [7:0]         status;

	nrf_sequencer #(
		.PAYLOAD_BYTES(PAYLOAD_BYTES),
		.CE_HOLD_CYCLES(CE_HOLD_CYCLES)
	) u_seq (
		.CLK(CLK), .RSTn(RSTn), .IRQ(IRQ), .CE(CE),
		.cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_data(cmd_data),
		.txn_done(txn_done), .status(status), .tx_level(tx_level)
	);

	nrf_fifo #(.entry_t(nrf_txn_t), .DEPTH(CMD_DEPTH)) u_cmd_fifo (   // radio transactions
		.CLK(CLK), .RSTn(RSTn),
		.in_valid(cmd_valid), .in_ready(cmd_ready), .in_data(cmd_data),
		.out_valid(txn_valid), .out_ready(txn_ready), .out_data(txn_data),
		.level()
	);

	nrf_fifo #(.entry_t(logic [7:0]), .DEPTH(TXQ_DEPTH)) u_tx_fifo (  // host payload bytes
		.CLK(CLK), .RSTn(RSTn),
		.in_valid(tx_valid), .in_ready(tx_ready), .in_data(tx_data),
		.out_valid(txq_valid), .out_ready(txq_ready), .out_data(txq_data),
		.level(tx_level)
	);

	nrf_fifo #(.entry_t(nrf_rx_t), .DEPTH(RXQ_DEPTH)) u_rx_fifo (     // received payload
		.CLK(CLK), .RSTn(RSTn),
		.in_valid(rxq_valid), .in_ready(rxq_ready), .in_data(rxq_data),
		.out_valid(rx_valid), .out_ready(rx_ready), .out_data(rx_data),
		.level()
	);

	nrf_txn_engine #(.PAYLOAD_BYTES(PAYLOAD_BYTES)) u_engine (
		.CLK(CLK), .RSTn(RSTn),
		.txn_valid(txn_valid), .txn_ready(txn_ready), .txn_data(txn_data),
		.txq_valid(txq_valid), .txq_ready(txq_ready), .txq_data(txq_data),
		.rxq_valid(rxq_valid), .rxq_ready(rxq_ready), .rxq_data(rxq_data),
		.spi_valid(spi_valid), .spi_ready(spi_ready), .spi_data(spi_data),
		.spi_rx_valid(spi_rx_valid), .spi_rx_data(spi_rx_data),
		.CSN(CSN), .txn_done(txn_done), .status(status)
	);

endmodule

// ==== hw/nrf_txn_engine.sv ====
// spi transaction engine with opcode and data bytes, status capture and read data routing
`timescale 1ns/1ns

module nrf_txn_engine import nrf_pkg::*; #(
	parameter int PAYLOAD_BYTES = 32
) (
	input  logic       CLK,
	input  logic       RSTn,
	input  logic       txn_valid,
	output logic       txn_ready,
	input  nrf_txn_t   txn_data,
	input  logic       txq_valid,
	output logic       txq_ready,
	input  logic [7:0] txq_data,
	output logic       rxq_valid,
	input  logic       rxq_ready,
	output nrf_rx_t    rxq_data,
	output logic       spi_valid,
	input  logic       spi_ready,
	output logic [7:0] spi_data,
	input  logic       spi_rx_valid,
	input  logic [7:0] spi_rx_data,
	output logic       CSN,
	output logic       txn_done,
	output logic [7:0] status
);

	localparam logic [5:0] MAX_LEN = 6'(PAYLOAD_BYTES);

	typedef enum logic [1:0] {E_IDLE, E_SEND, E_WAIT} eng_state_e;

	eng_state_e st;
	nrf_txn_t   txn_q;
	logic [5:0] len_in;
	logic [5:0] len_q;
	logic [5:0] cnt;                // 0 is the opcode byte
	logic [2:0] addr_idx;
	logic       data_phase;
	logic       is_pld;
	logic       src_ok;
	logic       accept;

	// payload sources never run past the radio payload width
	assign is_pld = (txn_data.src == SRC_TXQ) || (txn_data.src == SRC_READ);
	assign len_in = (is_pld && txn_data.len > MAX_LEN) ? MAX_LEN : txn_data.len;

	assign txn_ready  = (st == E_IDLE);
	assign data_phase = (cnt != 6'd0);
	assign addr_idx   = cnt[2:0] - 3'd1;

	always_comb begin
		src_ok = 1'b1;
		if (data_phase) begin
			if (txn_q.src == SRC_TXQ) begin
				src_ok = txq_valid;           // wait for payload byte
			end else if (txn_q.src == SRC_READ) begin
				src_ok = rxq_ready;           // room for the reply
			end
		end
	end

	always_comb begin
		if (!data_phase) begin
			spi_data = txn_q.opcode;
		end else begin
			case (txn_q.src)
				SRC_FIXED: spi_data = txn_q.data;
				SRC_ADDR:  spi_data = NODE_ADDR[addr_idx];
				SRC_TXQ:   spi_data = txq_data;
				default:   spi_data = CMD_NOP;
			endcase
		end
	end

	assign spi_valid = (st == E_SEND) && src_ok;
	assign accept    = spi_valid & spi_ready;
	assign txq_ready = accept && data_phase && (txn_q.src == SRC_TXQ);

	assign rxq_valid     = (st == E_WAIT) && spi_rx_valid && data_phase && (txn_q.src == SRC_READ);
	assign rxq_data.data = spi_rx_data;
	assign rxq_data.last = (cnt == len_q);

	always_ff @(posedge CLK) begin
		if (txn_valid && txn_ready) begin
			txn_q <= txn_data;
			len_q <= len_in;
		end
		if (st == E_WAIT && spi_rx_valid && !data_phase) begin
			status <= spi_rx_data;            // first reply is the status register
		end
	end

	always_ff @(posedge CLK or negedge RSTn) begin
		if (!RSTn) begin
			st       <= E_IDLE;
			cnt      <= '0;
			CSN      <= 1'b1;
			txn_done <= 1'b0;
		end else begin
			txn_done <= 1'b0;
			case (st)
				E_IDLE: begin
					if (txn_valid) begin
						st  <= E_SEND;
						cnt <= '0;
						CSN <= 1'b0;
					end
				end
				E_SEND: begin
					if (accept) begin
						st <= E_WAIT;
					end
				end
				default: begin
					if (spi_rx_valid) begin
						if (cnt == len_q) begin
							st       <= E_IDLE;
							CSN      <= 1'b1;
							txn_done <= 1'b1;
						end else begin
							st  <= E_SEND;
							cnt <= cnt + 1'b1;
						end
					end
				end
			endcase
		end
	end

endmodule
